// ==== common/rv32_settings.svh ====
`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

// Local SRAM depth in 32-bit words
`define SRAM_WORDS 1024

// Region select bits at the top of the management address
`define MGMT_REGION_HI 15
`define MGMT_REGION_LO 14

// System region offsets
`define SYS_PC_SET 14'h0000
`define SYS_PC_JUMP 14'h0004
`define SYS_PC_STEP 14'h0008
`define SYS_INSTR 14'h0010
`define SYS_CTRL 14'h0020
`define SYS_ERROR 14'h0024

`endif

// ==== common/rv32Pkg.sv ====
package rv32Pkg;

	// Core run state, codes follow the probe encoding
	typedef enum logic [1:0] {
		stateHalt = 2'b00,
		stateFetch = 2'b10,
		stateExecute = 2'b11
	} coreState_t;

	// RV32I major opcodes
	typedef enum logic [6:0] {
		opLui = 7'b0110111,
		opAuipc = 7'b0010111,
		opJal = 7'b1101111,
		opJalr = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad = 7'b0000011,
		opStore = 7'b0100011,
		opImm = 7'b0010011,
		opReg = 7'b0110011,
		opFence = 7'b0001111,
		opSystem = 7'b1110011
	} opcode_t;

	// ALU function, same codes as funct3
	typedef enum logic [2:0] {
		aluAdd = 3'b000,
		aluSll = 3'b001,
		aluSlt = 3'b010,
		aluSltu = 3'b011,
		aluXor = 3'b100,
		aluSrl = 3'b101,
		aluOr = 3'b110,
		aluAnd = 3'b111
	} aluOp_t;

	// Alternate selects SUB and SRA
	typedef struct packed {
		aluOp_t op;
		logic alt;
	} aluCtrl_t;

	typedef struct packed {
		logic [1:0] reserved;
		logic misaligned;
		logic invalidInstruction;
	} errorCode_t;

	typedef enum logic [1:0] {
		regionSystem = 2'b00,
		regionRegisters = 2'b01,
		regionSram = 2'b10
	} mgmtRegion_t;

endpackage

// ==== common/memBusIf.sv ====
`timescale 1ns/100ps

interface memBusIf;
	logic [31:0] address;
	logic [3:0] byteSelect;
	logic writeEnable;
	logic readEnable;
	logic [31:0] writeData;
	logic [31:0] readData;
	logic busy;

	modport core (
		output address, byteSelect, writeEnable, readEnable, writeData,
		input readData, busy
	);

	modport memory (
		input address, byteSelect, writeEnable, readEnable, writeData,
		output readData, busy
	);
endinterface

// ==== core/rv32iAlu.sv ====
`timescale 1ns/100ps

module rv32iAlu (
	input logic [31:0] operandA,
	input logic [31:0] operandB,
	input rv32Pkg::aluCtrl_t ctrl,
	output logic [31:0] result,
	output logic [31:0] sum,
	output logic takeBranch
);
	logic [2:0] funct3;
	logic [32:0] difference;
	logic equal;
	logic lessSigned;
	logic lessUnsigned;
	logic isLeftShift;
	logic [31:0] shiftInput;
	logic signed [32:0] shiftWide;
	logic [31:0] rightShift;

	function automatic logic [31:0] reverseBits(input logic [31:0] value);
		logic [31:0] reversed;
		for (int i = 0; i < 32; i++)
			reversed[i] = value[31 - i];
		return reversed;
	endfunction

	assign funct3 = ctrl.op;
	assign sum = operandA + operandB;

	// One subtract serves all compares
	assign difference = {1'b0, operandA} - {1'b0, operandB};
	assign equal = difference[31:0] == 32'b0;
	assign lessUnsigned = difference[32];
	assign lessSigned = (operandA[31] ^ operandB[31]) ? operandA[31] : difference[32];

	// Left shift reuses the right shifter on reversed bits
	assign isLeftShift = ctrl.op == rv32Pkg::aluSll;
	assign shiftInput = isLeftShift ? reverseBits(operandA) : operandA;
	assign shiftWide = $signed({ctrl.alt && shiftInput[31] && !isLeftShift, shiftInput})
		>>> operandB[4:0];
	assign rightShift = shiftWide[31:0];

	always_comb begin
		case (ctrl.op)
			rv32Pkg::aluAdd: result = ctrl.alt ? difference[31:0] : sum;
			rv32Pkg::aluSll: result = reverseBits(rightShift);
			rv32Pkg::aluSlt: result = {31'b0, lessSigned};
			rv32Pkg::aluSltu: result = {31'b0, lessUnsigned};
			rv32Pkg::aluXor: result = operandA ^ operandB;
			rv32Pkg::aluSrl: result = rightShift;
			rv32Pkg::aluOr: result = operandA | operandB;
			default: result = operandA & operandB;
		endcase
	end

	// Branch funct3, codes 010 and 011 never branch
	always_comb begin
		case (funct3)
			3'b000: takeBranch = equal;
			3'b001: takeBranch = !equal;
			3'b100: takeBranch = lessSigned;
			3'b101: takeBranch = !lessSigned;
			3'b110: takeBranch = lessUnsigned;
			3'b111: takeBranch = !lessUnsigned;
			default: takeBranch = 1'b0;
		endcase
	end
endmodule

// ==== core/rv32iCore.sv ====
`timescale 1ns/100ps

module rv32iCore (
	input logic clk,
	input logic rst,
	input logic run,
	input logic pcSet,
	input logic pcJump,
	input logic pcStep,
	input logic regWrite,
	input logic [4:0] regIndex,
	input logic [31:0] mgmtWriteData,
	output logic [31:0] regReadData,
	output logic [31:0] instruction,
	memBusIf.core mem,
	output rv32Pkg::coreState_t state,
	output logic [31:0] programCounter,
	output rv32Pkg::errorCode_t errorCode
);
	logic [31:0] registers [32];

	rv32Pkg::opcode_t opcode;
	logic [4:0] rdIndex, rs1Index, rs2Index;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [31:0] immI, immS, immB, immU, immJ;
	logic isLui, isAuipc, isJal, isJalr, isBranch, isLoad, isStore;
	logic isAluImm, isAlu, isFence, isSystem, isCompressed;
	logic invalidInstruction;

	logic [31:0] rs1Value, rs2Value, operandA, operandB;
	rv32Pkg::aluCtrl_t aluCtrl;
	logic [31:0] aluResult, aluSum;
	logic takeBranch;

	logic [31:0] linkPc, branchTarget, nextPc, jumpTarget;
	logic jumpTaken;
	logic [3:0] sizeMask;
	logic [6:0] laneMask;
	logic isAccess, misaligned, hasError, dataAccess, retire, writesRd;
	rv32Pkg::errorCode_t execError;
	logic [31:0] loadLanes, loadValue, rdValue;

	assign opcode = rv32Pkg::opcode_t'(instruction[6:0]);
	assign rdIndex = instruction[11:7];
	assign rs1Index = instruction[19:15];
	assign rs2Index = instruction[24:20];
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];

	assign immI = {{21{instruction[31]}}, instruction[30:20]};
	assign immS = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
	assign immB = {{20{instruction[31]}}, instruction[7], instruction[30:25],
		instruction[11:8], 1'b0};
	assign immU = {instruction[31:12], 12'h000};
	assign immJ = {{12{instruction[31]}}, instruction[19:12], instruction[20],
		instruction[30:21], 1'b0};

	assign isLui = opcode == rv32Pkg::opLui;
	assign isAuipc = opcode == rv32Pkg::opAuipc;
	assign isJal = opcode == rv32Pkg::opJal;
	assign isJalr = (opcode == rv32Pkg::opJalr) && (funct3 == 3'b000);
	assign isBranch = (opcode == rv32Pkg::opBranch) && (funct3[2:1] != 2'b01);
	assign isLoad = (opcode == rv32Pkg::opLoad) && (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
	assign isStore = (opcode == rv32Pkg::opStore) && (funct3[2] == 1'b0) && (funct3 != 3'b011);
	assign isAluImm = (opcode == rv32Pkg::opImm)
		&& (funct3 != 3'b001 || funct7 == 7'b0000000)
		&& (funct3 != 3'b101 || funct7 == 7'b0000000 || funct7 == 7'b0100000);
	assign isAlu = (opcode == rv32Pkg::opReg) && (funct7 == 7'b0000000
		|| (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
	assign isFence = (opcode == rv32Pkg::opFence) && (funct3 == 3'b000);
	assign isSystem = opcode == rv32Pkg::opSystem;
	assign isCompressed = instruction[1:0] != 2'b11;

	// Compressed words match no opcode and end up here too
	assign invalidInstruction = !(isLui || isAuipc || isJal || isJalr || isBranch || isLoad
		|| isStore || isAluImm || isAlu || isFence || isSystem);

	assign rs1Value = (rs1Index != 5'd0) ? registers[rs1Index] : 32'b0;
	assign rs2Value = (rs2Index != 5'd0) ? registers[rs2Index] : 32'b0;
	assign regReadData = (regIndex != 5'd0) ? registers[regIndex] : 32'b0;

	assign operandA = isAuipc ? programCounter : rs1Value;
	assign operandB = isAuipc ? immU :
		(isAluImm || isLoad || isJalr) ? immI :
		isStore ? immS : rs2Value;

	assign aluCtrl.op = rv32Pkg::aluOp_t'(funct3);
	assign aluCtrl.alt = instruction[30] && (isAlu || (isAluImm && funct3 == 3'b101));

	rv32iAlu rv32iAlu_inst (
		.operandA(operandA),
		.operandB(operandB),
		.ctrl(aluCtrl),
		.result(aluResult),
		.sum(aluSum),
		.takeBranch(takeBranch)
	);

	// Next PC
	assign linkPc = programCounter + (isCompressed ? 32'd2 : 32'd4);
	assign branchTarget = programCounter + (isJal ? immJ : immB);
	assign jumpTaken = isJal || isJalr || (isBranch && takeBranch);
	assign nextPc = isJalr ? {aluSum[31:1], 1'b0} : jumpTaken ? branchTarget : linkPc;
	assign jumpTarget = programCounter + mgmtWriteData;

	// Byte lanes of a load or store
	always_comb begin
		case (funct3[1:0])
			2'b00: sizeMask = 4'b0001;
			2'b01: sizeMask = 4'b0011;
			2'b10: sizeMask = 4'b1111;
			default: sizeMask = 4'b0000;
		endcase
	end

	assign laneMask = {3'b000, sizeMask} << aluSum[1:0];
	assign isAccess = isLoad || isStore;
	assign misaligned = (isAccess && (laneMask[6:4] != 3'b000)) || (jumpTaken && nextPc[1]);
	assign execError = '{reserved: 2'b00, misaligned: misaligned,
		invalidInstruction: invalidInstruction};
	assign hasError = errorCode != '0;

	assign dataAccess = (state == rv32Pkg::stateExecute) && !hasError && (execError == '0)
		&& isAccess;
	assign mem.readEnable = (state == rv32Pkg::stateFetch) || (dataAccess && isLoad);
	assign mem.writeEnable = dataAccess && isStore;
	assign mem.address = (state == rv32Pkg::stateFetch) ? {programCounter[31:2], 2'b00}
		: {aluSum[31:2], 2'b00};
	assign mem.byteSelect = (state == rv32Pkg::stateFetch) ? 4'b1111 : laneMask[3:0];
	assign mem.writeData = rs2Value << {aluSum[1:0], 3'b000};

	// funct3 bit 2 marks unsigned loads
	assign loadLanes = mem.readData >> {aluSum[1:0], 3'b000};
	always_comb begin
		case (funct3[1:0])
			2'b00: loadValue = {{24{!funct3[2] && loadLanes[7]}}, loadLanes[7:0]};
			2'b01: loadValue = {{16{!funct3[2] && loadLanes[15]}}, loadLanes[15:0]};
			default: loadValue = loadLanes;
		endcase
	end

	assign writesRd = isLui || isAuipc || isJal || isJalr || isLoad || isAlu || isAluImm;
	assign rdValue = isLui ? immU :
		isAuipc ? aluSum :
		(isJal || isJalr) ? linkPc :
		isLoad ? loadValue : aluResult;

	assign retire = (state == rv32Pkg::stateExecute) && !hasError && (execError == '0)
		&& (!isAccess || !mem.busy);

	always_ff @(posedge clk) begin
		if (regWrite && state == rv32Pkg::stateHalt)
			registers[regIndex] <= mgmtWriteData;
		else if (retire && writesRd && rdIndex != 5'd0)
			registers[rdIndex] <= rdValue;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rv32Pkg::stateHalt;
			programCounter <= 32'b0;
			errorCode <= '0;
			instruction <= 32'b0;
		end else if (!hasError) begin
			case (state)
				rv32Pkg::stateHalt: begin
					if (run || pcStep)
						state <= rv32Pkg::stateFetch;
					else if (pcSet)
						programCounter <= {mgmtWriteData[31:1], 1'b0};
					else if (pcJump)
						programCounter <= {jumpTarget[31:1], 1'b0};
				end
				rv32Pkg::stateFetch: begin
					if (!mem.busy) begin
						instruction <= mem.readData;
						state <= rv32Pkg::stateExecute;
					end
				end
				rv32Pkg::stateExecute: begin
					// Sticky error, the core parks here
					if (execError != '0) begin
						errorCode <= execError;
					end else if (retire) begin
						programCounter <= {nextPc[31:1], 1'b0};
						state <= run ? rv32Pkg::stateFetch : rv32Pkg::stateHalt;
					end
				end
				default: state <= rv32Pkg::stateHalt;
			endcase
		end
	end
endmodule

// ==== src/mgmtApbBridge.sv ====
`timescale 1ns/100ps
`include "rv32_settings.svh"

module mgmtApbBridge (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`MGMT_REGION_HI:0] paddr,
	input logic [31:0] pwdata,
	input logic [3:0] pstrb,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic run,
	output logic pcSet,
	output logic pcJump,
	output logic pcStep,
	output logic regWrite,
	output logic [4:0] regIndex,
	output logic [31:0] mgmtWriteData,
	input logic [31:0] regReadData,
	input logic [31:0] programCounter,
	input logic [31:0] instruction,
	input rv32Pkg::coreState_t state,
	input rv32Pkg::errorCode_t errorCode,
	output logic hostEnable,
	output logic hostWrite,
	output logic [$clog2(`SRAM_WORDS)-1:0] hostAddress,
	output logic [3:0] hostStrobe,
	output logic [31:0] hostWriteData,
	input logic [31:0] hostReadData
);
	localparam int AddrBits = $clog2(`SRAM_WORDS);

	rv32Pkg::mgmtRegion_t region;
	logic [`MGMT_REGION_LO-1:0] offset;
	logic access;
	logic halted;
	logic selPcSet, selPcJump, selPcStep, selInstr, selCtrl, selError;
	logic selReg;
	logic selSram;
	logic sramReadOk;
	logic readWait;
	logic decodeError;
	logic complete;
	logic [31:0] readValue;

	assign region = rv32Pkg::mgmtRegion_t'(paddr[`MGMT_REGION_HI:`MGMT_REGION_LO]);
	assign offset = paddr[`MGMT_REGION_LO-1:0];
	assign access = psel && penable;

	// Core commands and host access need a stopped core
	assign halted = (state == rv32Pkg::stateHalt) && !run;

	assign selPcSet = (region == rv32Pkg::regionSystem) && (offset == `SYS_PC_SET);
	assign selPcJump = (region == rv32Pkg::regionSystem) && (offset == `SYS_PC_JUMP);
	assign selPcStep = (region == rv32Pkg::regionSystem) && (offset == `SYS_PC_STEP);
	assign selInstr = (region == rv32Pkg::regionSystem) && (offset == `SYS_INSTR);
	assign selCtrl = (region == rv32Pkg::regionSystem) && (offset == `SYS_CTRL);
	assign selError = (region == rv32Pkg::regionSystem) && (offset == `SYS_ERROR);
	assign selReg = (region == rv32Pkg::regionRegisters) && (offset[`MGMT_REGION_LO-1:7] == '0);
	assign selSram = (region == rv32Pkg::regionSram) && (offset[`MGMT_REGION_LO-1:2] < `SRAM_WORDS);

	always_comb begin
		readValue = '0;
		decodeError = 1'b1;
		if (selPcSet || selPcJump || selPcStep) begin
			readValue = programCounter;
			decodeError = pwrite && !halted;
		end else if (selInstr) begin
			readValue = instruction;
			decodeError = pwrite;
		end else if (selCtrl) begin
			readValue = {29'b0, state, run};
			decodeError = 1'b0;
		end else if (selError) begin
			readValue = {28'b0, errorCode};
			decodeError = pwrite;
		end else if (selReg) begin
			readValue = regReadData;
			decodeError = pwrite && !halted;
		end else if (selSram) begin
			readValue = hostReadData;
			decodeError = !halted;
		end
	end

	// SRAM reads wait one cycle for the registered host data
	assign sramReadOk = selSram && !pwrite && halted;
	assign pready = access && (!sramReadOk || readWait);
	assign pslverr = pready && decodeError;
	assign complete = pready && !decodeError;

	always_ff @(posedge clk) begin
		if (rst) begin
			readWait <= 1'b0;
			run <= 1'b0;
		end else begin
			readWait <= access && sramReadOk && !readWait;
			if (complete && pwrite && selCtrl)
				run <= pwdata[0];
		end
	end

	assign pcSet = complete && pwrite && selPcSet;
	assign pcJump = complete && pwrite && selPcJump;
	assign pcStep = complete && pwrite && selPcStep;
	assign regWrite = complete && pwrite && selReg;
	assign regIndex = paddr[6:2];
	assign mgmtWriteData = pwdata;

	assign hostEnable = access && selSram && halted && !readWait;
	assign hostWrite = pwrite;
	assign hostAddress = paddr[AddrBits+1:2];
	assign hostStrobe = pstrb;
	assign hostWriteData = pwdata;

	assign prdata = {
		pstrb[3] ? readValue[31:24] : 8'h00,
		pstrb[2] ? readValue[23:16] : 8'h00,
		pstrb[1] ? readValue[15:8] : 8'h00,
		pstrb[0] ? readValue[7:0] : 8'h00
	};
endmodule

// ==== src/localSram.sv ====
`timescale 1ns/100ps
`include "rv32_settings.svh"

module localSram (
	input logic clk,
	input logic rst,
	memBusIf.memory mem,
	input logic hostEnable,
	input logic hostWrite,
	input logic [$clog2(`SRAM_WORDS)-1:0] hostAddress,
	input logic [3:0] hostStrobe,
	input logic [31:0] hostWriteData,
	output logic [31:0] hostReadData
);
	localparam int AddrBits = $clog2(`SRAM_WORDS);

	logic [31:0] memory [`SRAM_WORDS];
	logic coreRequest;
	logic ack;
	logic [AddrBits-1:0] coreAddress;

	assign coreRequest = mem.readEnable || mem.writeEnable;
	assign coreAddress = mem.address[AddrBits+1:2];

	// Busy in the first cycle of a request, done in the second
	assign mem.busy = coreRequest && !ack;

	always_ff @(posedge clk) begin
		if (rst)
			ack <= 1'b0;
		else
			ack <= coreRequest && !ack;
	end

	always_ff @(posedge clk) begin
		if (hostEnable && !hostWrite)
			hostReadData <= memory[hostAddress];
		if (coreRequest && !ack)
			mem.readData <= memory[coreAddress];
		// Host writes win over a core write in the same cycle
		for (int i = 0; i < 4; i++) begin
			if (hostEnable && hostWrite && hostStrobe[i])
				memory[hostAddress][8*i +: 8] <= hostWriteData[8*i +: 8];
			else if (!hostEnable && mem.writeEnable && ack && mem.byteSelect[i])
				memory[coreAddress][8*i +: 8] <= mem.writeData[8*i +: 8];
		end
	end
endmodule

// ==== src/rv32Subsystem.sv ====
`timescale 1ns/100ps
`include "rv32_settings.svh"

module rv32Subsystem (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`MGMT_REGION_HI:0] paddr,
	input logic [31:0] pwdata,
	input logic [3:0] pstrb,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output rv32Pkg::coreState_t state,
	output logic [31:0] programCounter,
	output rv32Pkg::errorCode_t errorCode
);
	logic run;
	logic pcSet, pcJump, pcStep, regWrite;
	logic [4:0] regIndex;
	logic [31:0] mgmtWriteData;
	logic [31:0] regReadData;
	logic [31:0] instruction;
	logic hostEnable;
	logic hostWrite;
	logic [$clog2(`SRAM_WORDS)-1:0] hostAddress;
	logic [3:0] hostStrobe;
	logic [31:0] hostWriteData;
	logic [31:0] hostReadData;

	memBusIf memBus ();

	mgmtApbBridge mgmtApbBridge_inst (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.run(run),
		.pcSet(pcSet),
		.pcJump(pcJump),
		.pcStep(pcStep),
		.regWrite(regWrite),
		.regIndex(regIndex),
		.mgmtWriteData(mgmtWriteData),
		.regReadData(regReadData),
		.programCounter(programCounter),
		.instruction(instruction),
		.state(state),
		.errorCode(errorCode),
		.hostEnable(hostEnable),
		.hostWrite(hostWrite),
		.hostAddress(hostAddress),
		.hostStrobe(hostStrobe),
		.hostWriteData(hostWriteData),
		.hostReadData(hostReadData)
	);

	rv32iCore rv32iCore_inst (
		.clk(clk),
		.rst(rst),
		.run(run),
		.pcSet(pcSet),
		.pcJump(pcJump),
		.pcStep(pcStep),
		.regWrite(regWrite),
		.regIndex(regIndex),
		.mgmtWriteData(mgmtWriteData),
		.regReadData(regReadData),
		.instruction(instruction),
		.mem(memBus.core),
		.state(state),
		.programCounter(programCounter),
		.errorCode(errorCode)
	);

	localSram localSram_inst (
		.clk(clk),
		.rst(rst),
		.mem(memBus.memory),
		.hostEnable(hostEnable),
		.hostWrite(hostWrite),
		.hostAddress(hostAddress),
		.hostStrobe(hostStrobe),
		.hostWriteData(hostWriteData),
		.hostReadData(hostReadData)
	);
endmodule

// ==== sim/clockGen.sv ====
`timescale 1ns/100ps

module clockGen (
	input logic resetRequest,
	output logic clk,
	output logic rst
);
	logic [1:0] cyclesLeft = 2'd2;

	initial clk = 1'b0;
	initial rst = 1'b1;

	always #50 clk = ~clk;

	// Reset spans three rising edges, again on each request
	always @(posedge clk) begin
		if (resetRequest) begin
			rst <= 1'b1;
			cyclesLeft <= 2'd2;
		end else if (cyclesLeft != 2'd0) begin
			cyclesLeft <= cyclesLeft - 2'd1;
		end else begin
			rst <= 1'b0;
		end
	end
endmodule

// ==== sim/rv32Subsystem_props.sv ====
`timescale 1ns/100ps

module rv32Subsystem_props (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic memRead,
	input logic memWrite,
	input logic memBusy,
	input logic [31:0] memAddress,
	input rv32Pkg::coreState_t state,
	input rv32Pkg::errorCode_t errorCode
);
	// At most one APB wait state
	waitOneCycle: assert property (@(posedge clk) disable iff (rst)
		(psel && penable && !pready) |=> pready)
		else $error("APB access stayed in a wait state for more than one cycle");

	// Request held for exactly one busy cycle
	requestHeld: assert property (@(posedge clk) disable iff (rst)
		((memRead || memWrite) && memBusy) |=>
		((memRead || memWrite) && $stable(memAddress) && !memBusy))
		else $error("memory request changed or stayed busy");

	oneDirection: assert property (@(posedge clk) disable iff (rst)
		!(memRead && memWrite))
		else $error("read and write enable together");

	// Errors park the core in execute
	errorSticky: assert property (@(posedge clk) disable iff (rst)
		(errorCode != '0) |=> ($stable(errorCode) && state == rv32Pkg::stateExecute))
		else $error("error code changed or core left execute after an error");
endmodule

// ==== sim/rv32SubsystemTb.sv ====
`timescale 1ns/100ps
`include "rv32_settings.svh"

module rv32SubsystemTb;
	typedef enum {
		opWrite, opRead, opWaitIdle, opWaitHalt,
		opExpectState, opExpectError, opExpectPc, opReset
	} tbOp_t;

	typedef struct {
		tbOp_t op;
		logic [15:0] addr;
		logic [31:0] data;
		logic [3:0] strb;
		logic [31:0] expRead;
		logic expErr;
	} entry_t;

	logic clk, rst, resetRequest;
	logic psel, penable, pwrite;
	logic [15:0] paddr;
	logic [31:0] pwdata;
	logic [3:0] pstrb;
	logic [31:0] prdata;
	logic pready, pslverr;
	rv32Pkg::coreState_t state;
	logic [31:0] programCounter;
	rv32Pkg::errorCode_t errorCode;

	entry_t entries[$];
	logic tableReady = 1'b0;
	logic [31:0] rngState;

	clockGen clockGen_inst (.resetRequest(resetRequest), .clk(clk), .rst(rst));

	rv32Subsystem rv32Subsystem_inst (
		.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .state(state),
		.programCounter(programCounter), .errorCode(errorCode)
	);

	bind rv32Subsystem rv32Subsystem_props props_inst (
		.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pready(pready),
		.memRead(memBus.readEnable), .memWrite(memBus.writeEnable),
		.memBusy(memBus.busy), .memAddress(memBus.address), .state(state),
		.errorCode(errorCode)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Instruction encoders
	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [15:0] sysAddr(input logic [13:0] offset);
		return {rv32Pkg::regionSystem, offset};
	endfunction

	function automatic logic [15:0] regAddr(input int index);
		return {rv32Pkg::regionRegisters, 14'(index * 4)};
	endfunction

	function automatic logic [15:0] sramAddr(input logic [13:0] byteAddress);
		return {rv32Pkg::regionSram, byteAddress};
	endfunction

	task automatic addEntry(input tbOp_t op, input logic [15:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [31:0] expRead, input logic expErr);
		entry_t e;
		e.op = op;
		e.addr = addr;
		e.data = data;
		e.strb = strb;
		e.expRead = expRead;
		e.expErr = expErr;
		entries.push_back(e);
	endtask

	task automatic addWrite(input logic [15:0] addr, input logic [31:0] data, input logic err);
		addEntry(opWrite, addr, data, 4'hf, 32'h0, err);
	endtask

	task automatic addRead(input logic [15:0] addr, input logic [3:0] strb,
		input logic [31:0] expected, input logic err);
		addEntry(opRead, addr, 32'h0, strb, expected, err);
	endtask

	task automatic addOp(input tbOp_t op, input logic [31:0] data);
		addEntry(op, 16'h0, data, 4'h0, 32'h0, 1'b0);
	endtask

	task automatic addStep(input logic [31:0] pcAfter, input int rd, input logic [31:0] value);
		addWrite(sysAddr(`SYS_PC_STEP), 32'h0, 1'b0);
		addOp(opWaitIdle, 32'h0);
		addOp(opExpectPc, pcAfter);
		if (rd != 0)
			addRead(regAddr(rd), 4'hf, value, 1'b0);
	endtask

	task automatic buildTable();
		logic [31:0] value;
		// Reset values
		addOp(opExpectState, 32'(rv32Pkg::stateHalt));
		addOp(opExpectPc, 32'h0);
		addOp(opExpectError, 32'h0);
		addRead(sysAddr(`SYS_PC_SET), 4'hf, 32'h0, 1'b0);
		rngState = 32'hd6c9_9b7d;
		for (int i = 24; i < 29; i++) begin
			rngState = xorshift32(rngState);
			addWrite(regAddr(i), rngState, 1'b0);
			addRead(regAddr(i), 4'hf, rngState, 1'b0);
		end
		addRead(regAddr(28), 4'b0101, rngState & 32'h00ff_00ff, 1'b0);
		rngState = xorshift32(rngState);
		addWrite(regAddr(0), rngState, 1'b0);
		addRead(regAddr(0), 4'hf, 32'h0, 1'b0);

		// Program image
		addWrite(sramAddr(14'h000), encI(12'hffd, 5'd2, 3'b000, 5'd3, 7'b0010011), 1'b0);
		addWrite(sramAddr(14'h004), encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 1'b0);
		addWrite(sramAddr(14'h008), encR(7'h20, 5'd1, 5'd2, 3'b000, 5'd5), 1'b0);
		addWrite(sramAddr(14'h00c), encR(7'h00, 5'd2, 5'd1, 3'b010, 5'd6), 1'b0);
		addWrite(sramAddr(14'h010), encR(7'h00, 5'd2, 5'd1, 3'b011, 5'd7), 1'b0);
		addWrite(sramAddr(14'h014), encR(7'h20, 5'd3, 5'd1, 3'b101, 5'd8), 1'b0);
		addWrite(sramAddr(14'h018), encR(7'h00, 5'd3, 5'd1, 3'b101, 5'd9), 1'b0);
		addWrite(sramAddr(14'h01c), encR(7'h00, 5'd3, 5'd2, 3'b001, 5'd10), 1'b0);
		addWrite(sramAddr(14'h020), {20'h12345, 5'd11, 7'b0110111}, 1'b0);
		addWrite(sramAddr(14'h024), {20'h00001, 5'd12, 7'b0010111}, 1'b0);
		addWrite(sramAddr(14'h028), encS(12'h000, 5'd14, 5'd13, 3'b010), 1'b0);
		addWrite(sramAddr(14'h02c), encI(12'h001, 5'd13, 3'b000, 5'd15, 7'b0000011), 1'b0);
		addWrite(sramAddr(14'h030), encI(12'h000, 5'd13, 3'b101, 5'd16, 7'b0000011), 1'b0);
		addWrite(sramAddr(14'h034), encI(12'h000, 5'd13, 3'b010, 5'd17, 7'b0000011), 1'b0);
		addWrite(sramAddr(14'h038), encS(12'h003, 5'd2, 5'd13, 3'b000), 1'b0);
		addWrite(sramAddr(14'h03c), encB(13'h008, 5'd2, 5'd2, 3'b000), 1'b0);
		addWrite(sramAddr(14'h040), 32'h0000_0013, 1'b0);
		addWrite(sramAddr(14'h044), encB(13'h008, 5'd1, 5'd2, 3'b100), 1'b0);
		addWrite(sramAddr(14'h048), encJ(21'h8, 5'd18), 1'b0);
		addWrite(sramAddr(14'h04c), 32'h0000_0013, 1'b0);
		addWrite(sramAddr(14'h050), encI(12'h060, 5'd0, 3'b000, 5'd19, 7'b1100111), 1'b0);
		addWrite(sramAddr(14'h060), encJ(21'h0, 5'd0), 1'b0);
		addWrite(sramAddr(14'h064), encI(12'h007, 5'd0, 3'b000, 5'd20, 7'b0010011), 1'b0);
		addWrite(sramAddr(14'h068), encI(12'h001, 5'd20, 3'b000, 5'd20, 7'b0010011), 1'b0);
		addWrite(sramAddr(14'h06c), 32'h0000_0000, 1'b0);
		addWrite(sramAddr(14'h070), encI(12'h002, 5'd13, 3'b010, 5'd21, 7'b0000011), 1'b0);
		addRead(sramAddr(14'h020), 4'hf, 32'h1234_55b7, 1'b0);
		addRead(sramAddr(14'h06c), 4'hf, 32'h0, 1'b0);
		addWrite(sramAddr(14'((`SRAM_WORDS - 1) * 4)), 32'hcafe_f00d, 1'b0);
		addRead(sramAddr(14'((`SRAM_WORDS - 1) * 4)), 4'hf, 32'hcafe_f00d, 1'b0);

		// PC set clears bit 0, jump adds to PC
		addWrite(sysAddr(`SYS_PC_SET), 32'h0000_0101, 1'b0);
		addRead(sysAddr(`SYS_PC_SET), 4'hf, 32'h0000_0100, 1'b0);
		addWrite(sysAddr(`SYS_PC_JUMP), 32'h0000_0010, 1'b0);
		addOp(opExpectPc, 32'h0000_0110);
		addWrite(sysAddr(`SYS_PC_SET), 32'h0, 1'b0);

		addWrite(regAddr(1), 32'hffff_ff00, 1'b0);
		addWrite(regAddr(2), 32'h0000_0005, 1'b0);
		addWrite(regAddr(13), 32'h0000_0200, 1'b0);
		addWrite(regAddr(14), 32'h1234_80f6, 1'b0);

		// Arithmetic steps
		addStep(32'h04, 3, 32'h0000_0002);
		addStep(32'h08, 4, 32'hffff_ff05);
		addStep(32'h0c, 5, 32'h0000_0105);
		addStep(32'h10, 6, 32'h0000_0001);
		addStep(32'h14, 7, 32'h0000_0000);
		addStep(32'h18, 8, 32'hffff_ffc0);
		addStep(32'h1c, 9, 32'h3fff_ffc0);
		addStep(32'h20, 10, 32'h0000_0014);
		addStep(32'h24, 11, 32'h1234_5000);
		addStep(32'h28, 12, 32'h0000_1024);

		// Memory and control flow
		addStep(32'h2c, 0, 32'h0);
		addRead(sramAddr(14'h200), 4'hf, 32'h1234_80f6, 1'b0);
		addStep(32'h30, 15, 32'hffff_ff80);
		addStep(32'h34, 16, 32'h0000_80f6);
		addStep(32'h38, 17, 32'h1234_80f6);
		addStep(32'h3c, 0, 32'h0);
		addRead(sramAddr(14'h200), 4'hf, 32'h0534_80f6, 1'b0);
		addStep(32'h44, 0, 32'h0);
		addStep(32'h48, 0, 32'h0);
		addStep(32'h50, 18, 32'h0000_004c);
		addStep(32'h60, 19, 32'h0000_0054);

		// Writes refused while the loop runs
		addWrite(sysAddr(`SYS_CTRL), 32'h1, 1'b0);
		addWrite(regAddr(5), 32'hdead_beef, 1'b1);
		addWrite(sramAddr(14'h060), 32'hdead_beef, 1'b1);
		addWrite(sysAddr(`SYS_CTRL), 32'h0, 1'b0);
		addOp(opWaitHalt, 32'h0);
		addOp(opExpectPc, 32'h60);
		addRead(regAddr(5), 4'hf, 32'h0000_0105, 1'b0);
		addRead(sramAddr(14'h060), 4'hf, encJ(21'h0, 5'd0), 1'b0);
		addRead(16'hc000, 4'hf, 32'h0, 1'b1);

		// Free run into an illegal word
		addWrite(sysAddr(`SYS_PC_SET), 32'h64, 1'b0);
		addWrite(sysAddr(`SYS_CTRL), 32'h1, 1'b0);
		addOp(opWaitIdle, 32'h0);
		addOp(opExpectState, 32'(rv32Pkg::stateExecute));
		addOp(opExpectError, 32'h1);
		addOp(opExpectPc, 32'h6c);
		addRead(sysAddr(`SYS_ERROR), 4'hf, 32'h1, 1'b0);
		addRead(regAddr(20), 4'hf, 32'h8, 1'b0);
		addWrite(sysAddr(`SYS_PC_STEP), 32'h0, 1'b1);
		addOp(opExpectState, 32'(rv32Pkg::stateExecute));
		addOp(opExpectPc, 32'h6c);
		addRead(sysAddr(`SYS_CTRL), 4'hf, 32'h7, 1'b0);

		// Misaligned load after a fresh reset
		addOp(opReset, 32'h0);
		addOp(opExpectState, 32'(rv32Pkg::stateHalt));
		addOp(opExpectError, 32'h0);
		addWrite(sysAddr(`SYS_PC_SET), 32'h70, 1'b0);
		addWrite(sysAddr(`SYS_PC_STEP), 32'h0, 1'b0);
		addOp(opWaitIdle, 32'h0);
		addOp(opExpectError, 32'h2);
		addOp(opExpectState, 32'(rv32Pkg::stateExecute));
		addOp(opExpectPc, 32'h70);
		value = 32'h2;
		addRead(sysAddr(`SYS_ERROR), 4'hf, value, 1'b0);
		addRead(sysAddr(`SYS_INSTR), 4'hf,
			encI(12'h002, 5'd13, 3'b010, 5'd21, 7'b0000011), 1'b0);
	endtask

	task automatic checkWord(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch %s: got %h, expected %h", name, actual, expected);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic checkState(input rv32Pkg::coreState_t actual,
		input rv32Pkg::coreState_t expected);
		if (actual !== expected) begin
			$display("Mismatch state: got %h, expected %h", actual, expected);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic checkError(input rv32Pkg::errorCode_t actual,
		input rv32Pkg::errorCode_t expected);
		if (actual !== expected) begin
			$display("Mismatch errorCode: got %h, expected %h", actual, expected);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// Drive on the falling edge, sample 10 ns before the rising edge
	task automatic apbTransfer(input logic write, input logic [15:0] addr,
		input logic [31:0] data, input logic [3:0] strb,
		output logic [31:0] readData, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		pstrb = strb;
		@(negedge clk);
		penable = 1'b1;
		#40;
		while (pready !== 1'b1) begin
			@(negedge clk);
			#40;
		end
		readData = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic applyEntry(input entry_t e);
		logic [31:0] readData;
		logic err;
		case (e.op)
			opWrite: begin
				apbTransfer(1'b1, e.addr, e.data, e.strb, readData, err);
				checkWord("pslverr", {31'b0, err}, {31'b0, e.expErr});
			end
			opRead: begin
				apbTransfer(1'b0, e.addr, 32'h0, e.strb, readData, err);
				checkWord("pslverr", {31'b0, err}, {31'b0, e.expErr});
				checkWord("prdata", readData, e.expRead);
			end
			opWaitIdle: begin
				while (state == rv32Pkg::stateHalt)
					@(negedge clk);
				while (state != rv32Pkg::stateHalt && errorCode == '0)
					@(negedge clk);
			end
			opWaitHalt: begin
				while (state != rv32Pkg::stateHalt)
					@(negedge clk);
			end
			opExpectState: checkState(state, rv32Pkg::coreState_t'(e.data[1:0]));
			opExpectError: checkError(errorCode, rv32Pkg::errorCode_t'(e.data[3:0]));
			opExpectPc: checkWord("programCounter", programCounter, e.data);
			opReset: begin
				@(negedge clk);
				resetRequest = 1'b1;
				@(negedge clk);
				resetRequest = 1'b0;
				while (rst)
					@(negedge clk);
			end
			default: ;
		endcase
	endtask

	initial begin
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 16'h0;
		pwdata = 32'h0;
		pstrb = 4'h0;
		resetRequest = 1'b0;
		buildTable();
		tableReady = 1'b1;
		@(negedge clk);
		while (rst)
			@(negedge clk);
		foreach (entries[i])
			applyEntry(entries[i]);
		$display("test passed");
		$finish;
	end

	// Watchdog sized from the table
	initial begin
		wait (tableReady);
		repeat (entries.size() * 40) @(posedge clk);
		$display("Timeout: the run did not finish within the expected number of cycles");
		$display("test failed");
		$fatal(1);
	end
endmodule

// ==== sources.f ====
+incdir+common
common/rv32Pkg.sv
common/memBusIf.sv
core/rv32iAlu.sv
core/rv32iCore.sv
src/mgmtApbBridge.sv
src/localSram.sv
src/rv32Subsystem.sv
sim/clockGen.sv
sim/rv32Subsystem_props.sv
sim/rv32SubsystemTb.sv

// ==== Bender.yml ====
package:
  name: rv32_subsystem

sources:
  - include_dirs:
      - common
    files:
      - common/rv32Pkg.sv
      - common/memBusIf.sv
      - core/rv32iAlu.sv
      - core/rv32iCore.sv
      - src/mgmtApbBridge.sv
      - src/localSram.sv
      - src/rv32Subsystem.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/clockGen.sv
      - sim/rv32Subsystem_props.sv
      - sim/rv32SubsystemTb.sv
